// ==== common/ics_periph_pkg.sv ====
/*
 * Shared types and address map for the peripheral side of the console SoC.
 * Everything runs on vdp_clk. The select field sits in address bits 19:16,
 * and select codes above SEL_FLASH_CTRL are unmapped and read back as zero.
 */

package ics_periph_pkg;

    // Host bus fields
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;

    // Peripheral payloads
    typedef logic signed [15:0] operand_t;
    typedef logic [1:0]         pad_ctrl_t;
    typedef logic [3:0]         flash_nibble_t;
    typedef logic [7:0]         led_t;

    // Decoder sequencing, one request in flight at a time
    typedef enum logic [1:0] {
        BUS_IDLE   = 2'd0,
        BUS_ENABLE = 2'd1,
        BUS_ACK    = 2'd2
    } bus_phase_t;

    // Peripheral select field in the address
    localparam int SEL_LSB = 16;
    localparam int SEL_MSB = 19;

    localparam logic [3:0] SEL_STATUS     = 4'd0;
    localparam logic [3:0] SEL_DSP        = 4'd1;
    localparam logic [3:0] SEL_PAD        = 4'd2;
    localparam logic [3:0] SEL_FLASH_CTRL = 4'd3;

    // Low picks operand A, high picks operand B
    localparam int DSP_OPERAND_BIT = 2;

    // Flash control register layout in the write data
    localparam int FLASH_IN_LSB     = 0;
    localparam int FLASH_IN_EN_LSB  = 4;
    localparam int FLASH_CLK_BIT    = 8;
    localparam int FLASH_CSN_BIT    = 9;
    localparam int FLASH_ACTIVE_BIT = 15;

    // Gamepad control bit positions
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

endpackage

// ==== hdl/address_decoder.sv ====
/*
 * Accepts one host request at a time and turns it into one-cycle enable pulses.
 * Pulses are high during the cycle after the request is sampled. New requests
 * are ignored until the ACK phase has passed, so the master must not re-raise
 * valid before it has seen ready.
 */

`timescale 1ns/1ps

module address_decoder (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,

    input  ics_periph_pkg::word_t   cpu_address,
    input  ics_periph_pkg::word_t   cpu_write_data,
    input  ics_periph_pkg::strobe_t cpu_wstrb,
    input  logic                    cpu_mem_valid,

    output logic                    status_write_en,
    output logic                    dsp_en,
    output logic                    dsp_write_en,
    output logic                    dsp_operand_b,
    output logic                    pad_en,
    output logic                    pad_write_en,
    output logic                    flash_ctrl_en,
    output logic                    flash_ctrl_write_en,
    output logic                    access,
    output logic                    any_write,
    output ics_periph_pkg::word_t   write_data
);
    import ics_periph_pkg::*;

    bus_phase_t phase;

    logic [3:0] sel;
    logic       is_write;
    logic       accept;

    assign sel      = cpu_address[SEL_MSB:SEL_LSB];
    assign is_write = |cpu_wstrb;
    assign accept   = (phase == BUS_IDLE) && cpu_mem_valid;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            phase               <= BUS_IDLE;
            access              <= 1'b0;
            any_write           <= 1'b0;
            status_write_en     <= 1'b0;
            dsp_en              <= 1'b0;
            dsp_write_en        <= 1'b0;
            pad_en              <= 1'b0;
            pad_write_en        <= 1'b0;
            flash_ctrl_en       <= 1'b0;
            flash_ctrl_write_en <= 1'b0;
        end else begin
            // Pulses only last one cycle
            access              <= accept;
            any_write           <= accept && is_write;
            status_write_en     <= accept && is_write && (sel == SEL_STATUS);
            dsp_en              <= accept && (sel == SEL_DSP);
            dsp_write_en        <= accept && is_write && (sel == SEL_DSP);
            pad_en              <= accept && (sel == SEL_PAD);
            pad_write_en        <= accept && is_write && (sel == SEL_PAD);
            flash_ctrl_en       <= accept && (sel == SEL_FLASH_CTRL);
            flash_ctrl_write_en <= accept && is_write && (sel == SEL_FLASH_CTRL);

            case (phase)
                BUS_IDLE: begin
                    if (cpu_mem_valid) begin
                        phase <= BUS_ENABLE;
                    end
                end
                BUS_ENABLE: phase <= BUS_ACK;
                // Ready is out during this phase
                BUS_ACK:    phase <= BUS_IDLE;
                default:    phase <= BUS_IDLE;
            endcase
        end
    end

    // Request payload, held until the next accepted request
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            write_data    <= cpu_write_data;
            dsp_operand_b <= cpu_address[DSP_OPERAND_BIT];
        end
    end

endmodule

// ==== hdl/bus_arbiter.sv ====
/*
 * Registers the ready pulse and read data one edge after the decoder enables.
 * Only the decoder enables are used to pick the source, no address is seen here.
 * Writes, status reads and unmapped reads return zero.
 */

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  access,
    input  logic                  any_write,
    input  logic                  status_write_en,

    input  logic                  dsp_en,
    input  ics_periph_pkg::word_t dsp_result,
    input  logic                  pad_en,
    input  ics_periph_pkg::word_t pad_read_data,
    input  logic                  flash_ctrl_en,
    input  ics_periph_pkg::word_t flash_ctrl_read_data,

    output ics_periph_pkg::word_t cpu_read_data,
    output logic                  cpu_mem_ready
);
    import ics_periph_pkg::*;

    word_t read_mux;
    logic  write_access;

    // Status register is write only, treat it like any other write
    assign write_access = any_write || status_write_en;

    always_comb begin
        read_mux = '0;
        if (!write_access) begin
            if (dsp_en) begin
                read_mux = dsp_result;
            end else if (pad_en) begin
                read_mux = pad_read_data;
            end else if (flash_ctrl_en) begin
                read_mux = flash_ctrl_read_data;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
        end else begin
            cpu_mem_ready <= access;
        end
    end

    // Data only needs to be valid alongside ready
    always_ff @(posedge vdp_clk) begin
        if (access) begin
            cpu_read_data <= read_mux;
        end
    end

endmodule

// ==== hdl/dsp_mult.sv ====
/*
 * Signed 16x16 multiplier with registered operands and product.
 * The product lags an operand write by one edge, which is always ahead of the
 * next read on this bus. No reset, so the flops can map into a DSP block.
 */

`timescale 1ns/1ps

module dsp_mult (
    input  logic                  vdp_clk,
    input  logic                  dsp_write_en,
    input  logic                  dsp_operand_b,
    input  ics_periph_pkg::word_t write_data,
    output ics_periph_pkg::word_t dsp_result
);
    import ics_periph_pkg::*;

    operand_t mult_a;
    operand_t mult_b;

    // Flat ifs keep the operand loads inside the DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (dsp_write_en && !dsp_operand_b) begin
            mult_a <= write_data[15:0];
        end

        if (dsp_write_en && dsp_operand_b) begin
            mult_b <= write_data[15:0];
        end

        dsp_result <= mult_a * mult_b;
    end

endmodule

// ==== hdl/io_regs.sv ====
/*
 * Status LED byte and gamepad control lines.
 * The LED register is write only. Pad readback is combinational from the
 * pins, so pad_data and user_button should already be synchronized.
 */

`timescale 1ns/1ps

module io_regs (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  status_write_en,
    input  logic                  pad_write_en,
    input  ics_periph_pkg::word_t write_data,

    input  logic [1:0]            pad_data,
    input  logic                  user_button,

    output ics_periph_pkg::led_t  led,
    output logic                  pad_latch,
    output logic                  pad_clk,
    output ics_periph_pkg::word_t pad_read_data
);
    import ics_periph_pkg::*;

    pad_ctrl_t pad_ctrl;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            led      <= '0;
            pad_ctrl <= '0;
        end else begin
            if (status_write_en) begin
                led <= write_data[7:0];
            end
            if (pad_write_en) begin
                pad_ctrl <= write_data[1:0];
            end
        end
    end

    assign pad_latch = pad_ctrl[PAD_LATCH_BIT];
    assign pad_clk   = pad_ctrl[PAD_CLK_BIT];

    // Button above the two serial data lines
    assign pad_read_data = {29'd0, user_button, pad_data};

endmodule

// ==== hdl/flash_ctrl.sv ====
/*
 * Bit-bang access to the quad flash pins from the host bus.
 * While the active bit is clear the pins sit at idle: csn high, clock low and
 * all lanes released. flash_out is expected to be registered at the IO pad.
 */

`timescale 1ns/1ps

module flash_ctrl (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,

    input  logic                          flash_ctrl_write_en,
    input  ics_periph_pkg::word_t         write_data,

    output logic [1:0]                    flash_clk_ddr,
    output logic                          flash_csn,
    output ics_periph_pkg::flash_nibble_t flash_in,
    output ics_periph_pkg::flash_nibble_t flash_in_en,
    input  ics_periph_pkg::flash_nibble_t flash_out,

    output ics_periph_pkg::word_t         flash_ctrl_read_data
);
    import ics_periph_pkg::*;

    logic          ctrl_active;
    flash_nibble_t ctrl_in;
    flash_nibble_t ctrl_in_en;
    logic          ctrl_clk;
    logic          ctrl_csn;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ctrl_active <= 1'b0;
        end else if (flash_ctrl_write_en) begin
            ctrl_active <= write_data[FLASH_ACTIVE_BIT];
        end
    end

    // Pin fields only matter once active is set
    always_ff @(posedge vdp_clk) begin
        if (flash_ctrl_write_en) begin
            ctrl_in    <= write_data[FLASH_IN_LSB +: 4];
            ctrl_in_en <= write_data[FLASH_IN_EN_LSB +: 4];
            ctrl_clk   <= write_data[FLASH_CLK_BIT];
            ctrl_csn   <= write_data[FLASH_CSN_BIT];
        end
    end

    // Same level on both DDR phases gives a plain SDR clock
    assign flash_clk_ddr = ctrl_active ? {2{ctrl_clk}} : 2'b00;
    assign flash_csn     = ctrl_active ? ctrl_csn : 1'b1;
    assign flash_in      = ctrl_active ? ctrl_in : 4'h0;
    assign flash_in_en   = ctrl_active ? ctrl_in_en : 4'h0;

    assign flash_ctrl_read_data = {28'd0, flash_out};

endmodule

// ==== hdl/ics_periph.sv ====
/*
 * Peripheral subsystem on vdp_clk: decoder, LED/pad registers, multiplier,
 * flash bit-bang control and the read arbiter.
 * Fixed latency, ready rises two edges after the request is sampled.
 */

`timescale 1ns/1ps

module ics_periph (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,

    input  ics_periph_pkg::word_t         cpu_address,
    input  ics_periph_pkg::word_t         cpu_write_data,
    input  ics_periph_pkg::strobe_t       cpu_wstrb,
    input  logic                          cpu_mem_valid,
    output ics_periph_pkg::word_t         cpu_read_data,
    output logic                          cpu_mem_ready,

    output ics_periph_pkg::led_t          led,

    output logic                          pad_latch,
    output logic                          pad_clk,
    input  logic [1:0]                    pad_data,
    input  logic                          user_button,

    output logic [1:0]                    flash_clk_ddr,
    output logic                          flash_csn,
    output ics_periph_pkg::flash_nibble_t flash_in,
    output ics_periph_pkg::flash_nibble_t flash_in_en,
    input  ics_periph_pkg::flash_nibble_t flash_out
);
    import ics_periph_pkg::*;

    logic  status_write_en;
    logic  dsp_en, dsp_write_en, dsp_operand_b;
    logic  pad_en, pad_write_en;
    logic  flash_ctrl_en, flash_ctrl_write_en;
    logic  access, any_write;
    word_t write_data;

    word_t dsp_result;
    word_t pad_read_data;
    word_t flash_ctrl_read_data;

    address_decoder i_address_decoder (
        .vdp_clk             (vdp_clk),
        .vdp_reset           (vdp_reset),
        .cpu_address         (cpu_address),
        .cpu_write_data      (cpu_write_data),
        .cpu_wstrb           (cpu_wstrb),
        .cpu_mem_valid       (cpu_mem_valid),
        .status_write_en     (status_write_en),
        .dsp_en              (dsp_en),
        .dsp_write_en        (dsp_write_en),
        .dsp_operand_b       (dsp_operand_b),
        .pad_en              (pad_en),
        .pad_write_en        (pad_write_en),
        .flash_ctrl_en       (flash_ctrl_en),
        .flash_ctrl_write_en (flash_ctrl_write_en),
        .access              (access),
        .any_write           (any_write),
        .write_data          (write_data)
    );

    dsp_mult i_dsp_mult (
        .vdp_clk       (vdp_clk),
        .dsp_write_en  (dsp_write_en),
        .dsp_operand_b (dsp_operand_b),
        .write_data    (write_data),
        .dsp_result    (dsp_result)
    );

    io_regs i_io_regs (
        .vdp_clk         (vdp_clk),
        .vdp_reset       (vdp_reset),
        .status_write_en (status_write_en),
        .pad_write_en    (pad_write_en),
        .write_data      (write_data),
        .pad_data        (pad_data),
        .user_button     (user_button),
        .led             (led),
        .pad_latch       (pad_latch),
        .pad_clk         (pad_clk),
        .pad_read_data   (pad_read_data)
    );

    flash_ctrl i_flash_ctrl (
        .vdp_clk              (vdp_clk),
        .vdp_reset            (vdp_reset),
        .flash_ctrl_write_en  (flash_ctrl_write_en),
        .write_data           (write_data),
        .flash_clk_ddr        (flash_clk_ddr),
        .flash_csn            (flash_csn),
        .flash_in             (flash_in),
        .flash_in_en          (flash_in_en),
        .flash_out            (flash_out),
        .flash_ctrl_read_data (flash_ctrl_read_data)
    );

    bus_arbiter i_bus_arbiter (
        .vdp_clk              (vdp_clk),
        .vdp_reset            (vdp_reset),
        .access               (access),
        .any_write            (any_write),
        .status_write_en      (status_write_en),
        .dsp_en               (dsp_en),
        .dsp_result           (dsp_result),
        .pad_en               (pad_en),
        .pad_read_data        (pad_read_data),
        .flash_ctrl_en        (flash_ctrl_en),
        .flash_ctrl_read_data (flash_ctrl_read_data),
        .cpu_read_data        (cpu_read_data),
        .cpu_mem_ready        (cpu_mem_ready)
    );

endmodule

// ==== sim/periph_checker.sv ====
/*
 * Watches the host bus and pins of ics_periph and compares them with a model.
 * Assumes one request at a time, ready expected exactly two edges after the
 * request is sampled. Multiplier operands are unknown until first written.
 */

`timescale 1ns/1ps

module periph_checker (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  ics_periph_pkg::word_t         cpu_address,
    input  ics_periph_pkg::word_t         cpu_write_data,
    input  ics_periph_pkg::strobe_t       cpu_wstrb,
    input  logic                          cpu_mem_valid,
    input  ics_periph_pkg::word_t         cpu_read_data,
    input  logic                          cpu_mem_ready,
    input  ics_periph_pkg::led_t          led,
    input  logic                          pad_latch,
    input  logic                          pad_clk,
    input  logic [1:0]                    pad_data,
    input  logic                          user_button,
    input  logic [1:0]                    flash_clk_ddr,
    input  logic                          flash_csn,
    input  ics_periph_pkg::flash_nibble_t flash_in,
    input  ics_periph_pkg::flash_nibble_t flash_in_en,
    input  ics_periph_pkg::flash_nibble_t flash_out,
    input  int                            test_id,
    input  logic                          test_done,
    input  logic                          all_done,
    output int                            total_errors
);
    import ics_periph_pkg::*;

    // Register model
    operand_t  op_a;
    operand_t  op_b;
    led_t      model_led;
    pad_ctrl_t model_pad;
    word_t     model_flash;

    // Request in flight
    int    stage;
    word_t req_addr;
    word_t req_data;
    logic  req_write;
    logic  check_idle;

    int test_checks;
    int test_errors;
    int all_checks;
    int tests_run;

    function automatic string test_name(input int id);
        case (id)
            1:       return "after reset";
            2:       return "bus timing";
            3:       return "multiplier";
            4:       return "led and gamepad";
            default: return "flash controller";
        endcase
    endfunction

    task automatic compare(input string name, input word_t expected, input word_t actual);
        test_checks++;
        all_checks++;
        if (actual !== expected) begin
            test_errors++;
            total_errors++;
            $display("error %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    // Inactive flash shows idle levels whatever the pin fields hold
    task automatic check_pins();
        logic active;
        active = model_flash[FLASH_ACTIVE_BIT];
        compare("led", model_led, led);
        compare("pad_latch", model_pad[0], pad_latch);
        compare("pad_clk", model_pad[1], pad_clk);
        compare("flash_csn", active ? model_flash[FLASH_CSN_BIT] : 1'b1, flash_csn);
        compare("flash_clk_ddr", active ? {2{model_flash[FLASH_CLK_BIT]}} : 2'b00,
                flash_clk_ddr);
        compare("flash_in", active ? model_flash[FLASH_IN_LSB +: 4] : 4'h0, flash_in);
        compare("flash_in_en", active ? model_flash[FLASH_IN_EN_LSB +: 4] : 4'h0, flash_in_en);
    endtask

    function automatic word_t expected_read(input word_t addr);
        logic signed [31:0] product;
        product = op_a * op_b;
        case (addr[SEL_MSB:SEL_LSB])
            SEL_DSP:        return product;
            SEL_PAD:        return {29'd0, user_button, pad_data};
            SEL_FLASH_CTRL: return {28'd0, flash_out};
            default:        return '0;
        endcase
    endfunction

    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            stage        = 0;
            model_led    = '0;
            model_pad    = '0;
            model_flash  = '0;
            check_idle   = 1'b1;
            test_checks  = 0;
            test_errors  = 0;
            all_checks   = 0;
            tests_run    = 0;
            total_errors = 0;
        end else begin
            if (check_idle) begin
                compare("cpu_mem_ready", 1'b0, cpu_mem_ready);
                check_pins();
                check_idle = 1'b0;
            end

            if (stage == 2) begin
                compare("cpu_mem_ready", 1'b1, cpu_mem_ready);
                compare("cpu_read_data", req_write ? '0 : expected_read(req_addr), cpu_read_data);
                check_pins();
                stage = 0;
            end else begin
                compare("cpu_mem_ready", 1'b0, cpu_mem_ready);
                if (stage == 1) begin
                    // Peripherals take the write at this edge
                    if (req_write) begin
                        case (req_addr[SEL_MSB:SEL_LSB])
                            SEL_STATUS:     model_led = req_data[7:0];
                            SEL_PAD:        model_pad = req_data[1:0];
                            SEL_FLASH_CTRL: model_flash = req_data;
                            SEL_DSP: begin
                                if (req_addr[DSP_OPERAND_BIT]) begin
                                    op_b = req_data[15:0];
                                end else begin
                                    op_a = req_data[15:0];
                                end
                            end
                            default: ;
                        endcase
                    end
                    stage = 2;
                end else if (cpu_mem_valid) begin
                    req_addr  = cpu_address;
                    req_data  = cpu_write_data;
                    req_write = |cpu_wstrb;
                    stage     = 1;
                end
            end

            if (test_done) begin
                tests_run++;
                $display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
                         test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (all_done) begin
                $display("tests %0d, checks %0d, errors %0d", tests_run, all_checks,
                         total_errors);
            end
        end
    end

endmodule

// ==== sim/tb_ics_periph.sv ====
/*
 * Testbench for ics_periph. Random bus traffic from a fixed seed, one request
 * at a time with at least one idle cycle between requests. Pad and flash
 * inputs only change while no request is outstanding.
 */

`timescale 1ns/1ps

module tb_ics_periph;
    import ics_periph_pkg::*;

    localparam int MULT_ROUNDS    = 20;
    localparam int IO_TRANS       = 40;
    localparam int FLASH_TRANS    = 40;
    localparam int MIX_TRANS      = 100;
    localparam int NUM_TRANS      = MULT_ROUNDS * 3 + IO_TRANS + FLASH_TRANS + MIX_TRANS;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 6 + 200;

    logic          vdp_clk;
    logic          vdp_reset;
    word_t         cpu_address;
    word_t         cpu_write_data;
    strobe_t       cpu_wstrb;
    logic          cpu_mem_valid;
    word_t         cpu_read_data;
    logic          cpu_mem_ready;
    led_t          led;
    logic          pad_latch;
    logic          pad_clk;
    logic [1:0]    pad_data;
    logic          user_button;
    logic [1:0]    flash_clk_ddr;
    logic          flash_csn;
    flash_nibble_t flash_in;
    flash_nibble_t flash_in_en;
    flash_nibble_t flash_out;

    int   test_id;
    logic test_done;
    logic all_done;
    int   total_errors;
    int   cycle_count = 0;

    initial begin
        vdp_clk = 1'b0;
        forever #20 vdp_clk = ~vdp_clk;
    end

    ics_periph i_dut (.*);

    periph_checker i_checker (.*);

    always @(posedge vdp_clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // Called just after a rising edge, returns 1 ns after the ready edge
    task automatic bus_access(input word_t addr, input word_t data, input logic write);
        repeat ($urandom_range(0, 2)) @(posedge vdp_clk);
        @(posedge vdp_clk);
        #1;
        cpu_address    = addr;
        cpu_write_data = data;
        cpu_wstrb      = write ? strobe_t'($urandom_range(1, 15)) : 4'h0;
        cpu_mem_valid  = 1'b1;
        do begin
            @(posedge vdp_clk);
        end while (cpu_mem_ready !== 1'b1);
        #1;
        cpu_mem_valid = 1'b0;
        pad_data      = 2'($urandom);
        user_button   = 1'($urandom);
        flash_out     = 4'($urandom);
    endtask

    function automatic word_t make_address(input logic [3:0] sel, input logic operand_b);
        word_t addr;
        addr = $urandom;
        addr[SEL_MSB:SEL_LSB] = sel;
        addr[DSP_OPERAND_BIT] = operand_b;
        return addr;
    endfunction

    task automatic random_access(input logic [3:0] sel);
        bus_access(make_address(sel, 1'($urandom)), $urandom, 1'($urandom));
    endtask

    task automatic end_test(input int next_id);
        test_done = 1'b1;
        @(posedge vdp_clk);
        #1;
        test_done = 1'b0;
        test_id   = next_id;
    endtask

    initial begin
        void'($urandom(32'h75bb));
        vdp_reset      = 1'b1;
        cpu_address    = '0;
        cpu_write_data = '0;
        cpu_wstrb      = '0;
        cpu_mem_valid  = 1'b0;
        pad_data       = 2'($urandom);
        user_button    = 1'($urandom);
        flash_out      = 4'($urandom);
        test_id        = 1;
        test_done      = 1'b0;
        all_done       = 1'b0;

        repeat (4) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;
        repeat (2) @(posedge vdp_clk);
        #1;
        end_test(3);

        // Both operands get written before any product is read
        repeat (MULT_ROUNDS) begin
            bus_access(make_address(SEL_DSP, 1'b0), $urandom, 1'b1);
            bus_access(make_address(SEL_DSP, 1'b1), $urandom, 1'b1);
            bus_access(make_address(SEL_DSP, 1'($urandom)), $urandom, 1'b0);
        end
        end_test(4);

        repeat (IO_TRANS) begin
            random_access($urandom_range(0, 1) ? SEL_PAD : SEL_STATUS);
        end
        end_test(5);

        repeat (FLASH_TRANS) begin
            random_access(SEL_FLASH_CTRL);
        end
        end_test(2);

        // Codes 4 and 5 are unmapped
        repeat (MIX_TRANS) begin
            random_access(4'($urandom_range(0, 5)));
        end
        end_test(0);

        all_done = 1'b1;
        @(posedge vdp_clk);
        #1;
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/ics_periph_pkg.sv
hdl/address_decoder.sv
hdl/bus_arbiter.sv
hdl/dsp_mult.sv
hdl/io_regs.sv
hdl/flash_ctrl.sv
hdl/ics_periph.sv
sim/periph_checker.sv
sim/tb_ics_periph.sv

// ==== Bender.yml ====
package:
  name: ics_periph

sources:
  - common/ics_periph_pkg.sv
  - hdl/address_decoder.sv
  - hdl/bus_arbiter.sv
  - hdl/dsp_mult.sv
  - hdl/io_regs.sv
  - hdl/flash_ctrl.sv
  - hdl/ics_periph.sv
  - target: simulation
    files:
      - sim/periph_checker.sv
      - sim/tb_ics_periph.sv
